//--- Bender.yml
package:
  name: vec_datapath

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/vdp_pkg.sv
      - src/inst_decode.sv
      - src/data_mem.sv
      - src/lane_alu.sv
      - src/vec_datapath.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/vec_datapath_assertions.sv
      - bench/tb_vec_datapath.sv

//--- bench/tb_vec_datapath.sv
`include "vdp_settings.svh"

module tb_vec_datapath;

    // Run length, one instruction per cycle
    localparam int RST_CYCLES = 8;
    localparam int FLUSH      = 4;
    localparam int N_ZERO     = 16;
    localparam int N_ARITH    = 200;
    localparam int N_RAW      = 16;
    localparam int N_ILLEGAL  = 40;
    localparam int N_DENSE    = 400;
    localparam int TOTAL      = RST_CYCLES + N_ZERO + 2 * `VDP_MEM_DEPTH + N_ARITH
                                + 3 * N_RAW + 2 * N_ILLEGAL + N_DENSE + 6 * FLUSH;
    localparam int LIMIT      = TOTAL + 50;
    localparam int LW         = `VDP_LANE_WIDTH;

    logic           clk = 1'b0;
    logic           arst_n;
    vdp_pkg::inst_t inst;
    logic           inst_vld;
    vdp_pkg::word_t wdata;
    vdp_pkg::word_t result;
    logic           result_vld;
    logic           illegal;

    // Reference model state
    vdp_pkg::word_t ref_mem [`VDP_MEM_DEPTH];
    vdp_pkg::word_t exp_q [$];
    logic           ref_pend;
    vdp_pkg::addr_t ref_pend_addr;
    // Compute flags of the last two sampled instructions
    logic [1:0]     calc_pipe;
    string          test_name;
    int             cycle_cnt = 0;

    vec_datapath vec_datapath_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst       (inst),
        .inst_vld   (inst_vld),
        .wdata      (wdata),
        .result     (result),
        .result_vld (result_vld),
        .illegal    (illegal)
    );

    always #20 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > LIMIT) begin
            $display("Simulation finished: FAIL");
            $fatal(1, "Timeout, run went past %0d cycles", LIMIT);
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    task automatic stop_on_failure(input string what);
        $display("Simulation finished: FAIL");
        $fatal(1, "%s", what);
    endtask

    task automatic check_word(input string name, input vdp_pkg::word_t exp,
                              input vdp_pkg::word_t act);
        if (act !== exp) begin
            $display("Error: %s expected %08h actual %08h", name, exp, act);
            stop_on_failure("Result word differs from the model");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error: %s expected %b actual %b", name, exp, act);
            stop_on_failure("Output flag differs from the model");
        end
    endtask

    //////////////////////////////////////////////////
    // Model
    //////////////////////////////////////////////////

    // Lanes worked out separately, so no carry can cross
    function automatic vdp_pkg::word_t lane_model(input logic [7:0] opc,
                                                  input vdp_pkg::word_t a,
                                                  input vdp_pkg::word_t b);
        vdp_pkg::word_t res;
        vdp_pkg::lane_t la;
        vdp_pkg::lane_t lb;
        logic [31:0]    prod;
        res = '0;
        for (int l = 0; l < 2; l++) begin
            la   = a[l*LW +: LW];
            lb   = b[l*LW +: LW];
            prod = {16'd0, la} * {16'd0, lb};
            if (opc == vdp_pkg::OP_ADD) begin
                res[l*LW +: LW] = la + lb;
            end else if (opc == vdp_pkg::OP_SUB) begin
                res[l*LW +: LW] = la - lb;
            end else if (opc == vdp_pkg::OP_MUL) begin
                res[l*LW +: LW] = prod[15:0];
            end else begin
                res[l*LW +: LW] = la;
            end
        end
        return res;
    endfunction

    // Upper half reserved, filled with noise
    function automatic vdp_pkg::inst_t make_inst(input logic [7:0] opc, input vdp_pkg::addr_t wa,
                                                 input vdp_pkg::addr_t ra0,
                                                 input vdp_pkg::addr_t ra1);
        return {32'($urandom), opc, wa, ra0, ra1};
    endfunction

    // One cycle: drive, wait for the edge, update model, check outputs
    task automatic step(input vdp_pkg::inst_t ins, input logic vld);
        logic [7:0]     opc;
        logic           calc;
        vdp_pkg::word_t exp;
        vdp_pkg::word_t wd;
        opc      = ins[31:24];
        calc     = vld && opc >= vdp_pkg::OP_ADD && opc <= vdp_pkg::OP_PASS;
        wd       = vdp_pkg::word_t'($urandom);
        inst     = ins;
        inst_vld = vld;
        wdata    = wd;
        @(posedge clk);
        #2;
        // Read-first, operands taken before the pending store lands
        exp = lane_model(opc, ref_mem[ins[15:8]], ref_mem[ins[7:0]]);
        if (ref_pend) begin
            ref_mem[ref_pend_addr] = wd;
        end
        ref_pend      = vld && opc == vdp_pkg::OP_STORE;
        ref_pend_addr = ins[23:16];
        calc_pipe     = {calc_pipe[0], calc};
        check_flag({test_name, " illegal"}, vld && opc > vdp_pkg::OP_PASS, illegal);
        if (result_vld && exp_q.size() == 0) begin
            stop_on_failure("result_vld went high with no result outstanding");
        end
        check_flag({test_name, " result_vld"}, calc_pipe[1], result_vld);
        if (result_vld) begin
            check_word(test_name, exp_q.pop_front(), result);
        end
        if (calc) begin
            exp_q.push_back(exp);
        end
    endtask

    task automatic drain();
        repeat (FLUSH) step('0, 1'b0);
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial begin
        logic [7:0] opc;
        void'($urandom(32'h0d26_0a2c));
        arst_n        = 1'b0;
        inst          = '0;
        inst_vld      = 1'b0;
        wdata         = '0;
        ref_pend      = 1'b0;
        ref_pend_addr = '0;
        calc_pipe     = '0;
        foreach (ref_mem[i]) begin
            ref_mem[i] = '0;
        end
        repeat (RST_CYCLES) @(posedge clk);
        #2;
        arst_n = 1'b1;
        check_flag("reset result_vld", 1'b0, result_vld);
        check_flag("reset illegal", 1'b0, illegal);

        // Unwritten words read back as zero
        test_name = "reset_reads";
        for (int i = 0; i < N_ZERO; i++) begin
            step(make_inst(vdp_pkg::OP_PASS, 8'($urandom), 8'($urandom), 8'($urandom)), 1'b1);
        end
        drain();

        // Back-to-back stores, then every word read back
        test_name = "store_all";
        for (int a = 0; a < `VDP_MEM_DEPTH; a++) begin
            step(make_inst(vdp_pkg::OP_STORE, 8'(a), 8'($urandom), 8'($urandom)), 1'b1);
        end
        test_name = "read_all";
        for (int a = 0; a < `VDP_MEM_DEPTH; a++) begin
            step(make_inst(vdp_pkg::OP_PASS, 8'($urandom), 8'(a), 8'($urandom)), 1'b1);
        end
        drain();

        test_name = "random_arith";
        for (int i = 0; i < N_ARITH; i++) begin
            opc = 8'(vdp_pkg::OP_ADD) + 8'($urandom % 3);
            step(make_inst(opc, 8'($urandom), 8'($urandom), 8'($urandom)), 1'b1);
        end
        drain();

        // Old word right after the store, new word one cycle later
        test_name = "read_after_store";
        for (int i = 0; i < N_RAW; i++) begin
            opc = 8'($urandom);
            step(make_inst(vdp_pkg::OP_STORE, opc, 8'($urandom), 8'($urandom)), 1'b1);
            step(make_inst(vdp_pkg::OP_PASS, 8'($urandom), opc, opc), 1'b1);
            step(make_inst(vdp_pkg::OP_ADD, 8'($urandom), opc, opc), 1'b1);
        end
        drain();

        // Unlisted opcode followed by a read of random memory
        test_name = "illegal_ops";
        for (int i = 0; i < N_ILLEGAL; i++) begin
            opc = 8'd6 + 8'($urandom % 250);
            step(make_inst(opc, 8'($urandom), 8'($urandom), 8'($urandom)), 1'b1);
            step(make_inst(vdp_pkg::OP_PASS, 8'($urandom), 8'($urandom), 8'($urandom)), 1'b1);
        end
        drain();

        // Narrow address range for frequent hazards
        test_name = "dense_mix";
        for (int i = 0; i < N_DENSE; i++) begin
            opc = ($urandom % 16 < 14) ? 8'($urandom % 6) : 8'd6 + 8'($urandom % 250);
            step(make_inst(opc, 8'($urandom % 16), 8'($urandom % 16), 8'($urandom % 16)),
                 $urandom % 10 < 8);
        end
        drain();

        if (exp_q.size() == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("Simulation finished: FAIL");
            $fatal(1, "%0d expected results never appeared", exp_q.size());
        end
    end

endmodule

//--- bench/vec_datapath_assertions.sv
`include "vdp_settings.svh"

module vec_datapath_assertions (
    input logic           clk,
    input logic           arst_n,
    input vdp_pkg::inst_t inst,
    input logic           inst_vld,
    input logic           wren,
    input logic           rden,
    input logic           result_vld,
    input logic           illegal
);

    // Valid instruction with an opcode outside the enum
    logic bad_opc;

    assign bad_opc = inst_vld
        && (inst[3*`VDP_ADDR_WIDTH +: `VDP_OPC_WIDTH] > 8'(vdp_pkg::OP_PASS));

    //////////////////////////////////////////////////
    // Latency
    //////////////////////////////////////////////////

    a_rden_to_vld: assert property (@(posedge clk) disable iff (!arst_n)
        rden |-> ##2 result_vld)
        else $error("result_vld missing two cycles after rden");

    a_vld_from_rden: assert property (@(posedge clk) disable iff (!arst_n)
        result_vld |-> $past(rden, 2))
        else $error("result_vld without a read two cycles before");

    // Store and compute are separate instructions
    a_wren_rden: assert property (@(posedge clk) disable iff (!arst_n)
        !(wren && rden))
        else $error("wren and rden high in the same cycle");

    //////////////////////////////////////////////////
    // Illegal strobe
    //////////////////////////////////////////////////

    a_bad_to_illegal: assert property (@(posedge clk) disable iff (!arst_n)
        bad_opc |=> illegal)
        else $error("illegal opcode gave no strobe");

    a_illegal_source: assert property (@(posedge clk) disable iff (!arst_n)
        illegal |-> $past(bad_opc))
        else $error("illegal strobe without a matching instruction");

endmodule

bind vec_datapath vec_datapath_assertions vec_datapath_assertions_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .inst       (inst),
    .inst_vld   (inst_vld),
    .wren       (wren),
    .rden       (rden),
    .result_vld (result_vld),
    .illegal    (illegal)
);

//--- src/data_mem.sv
`include "vdp_settings.svh"

module data_mem (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            wren,
    input  logic            rden,
    input  vdp_pkg::addr_t  waddr,
    input  vdp_pkg::addr_t  raddr0,
    input  vdp_pkg::addr_t  raddr1,
    input  vdp_pkg::word_t  wdata,
    output vdp_pkg::word_t  rdata0,
    output vdp_pkg::word_t  rdata1
);

    // Storage array
    vdp_pkg::word_t mem [`VDP_MEM_DEPTH];

    // Store waiting for its data
    logic           pend_vld;
    vdp_pkg::addr_t pend_addr;

    //////////////////////////////////////////////////
    // Pending store
    //////////////////////////////////////////////////

    // Flag follows wren one cycle late
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pend_vld <= 1'b0;
        end else begin
            pend_vld <= wren;
        end
    end

    // Address captured with the store instruction
    // Reloaded every store, so back-to-back stores overlap
    always_ff @(posedge clk) begin
        if (wren) begin
            pend_addr <= waddr;
        end
    end

    //////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////

    // Cleared on reset, written when data arrives
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `VDP_MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (pend_vld) begin
            mem[pend_addr] <= wdata;
        end
    end

    //////////////////////////////////////////////////
    // Read ports
    //////////////////////////////////////////////////

    // Read-first
    // Same-edge write lands after the old word is taken
    // Data held between reads
    always_ff @(posedge clk) begin
        if (rden) begin
            rdata0 <= mem[raddr0];
            rdata1 <= mem[raddr1];
        end
    end

endmodule

//--- src/inst_decode.sv
`include "vdp_settings.svh"

module inst_decode (
    input  logic              clk,
    input  logic              arst_n,
    input  vdp_pkg::inst_t    inst,
    input  logic              inst_vld,
    output logic              wren,
    output logic              rden,
    output vdp_pkg::addr_t    waddr,
    output vdp_pkg::addr_t    raddr0,
    output vdp_pkg::addr_t    raddr1,
    output vdp_pkg::alu_op_e  alu_op,
    output logic              illegal
);

    // Field boundaries inside the instruction
    localparam int AW      = `VDP_ADDR_WIDTH;
    localparam int OPC_LSB = 3 * `VDP_ADDR_WIDTH;

    // Raw opcode bits
    logic [`VDP_OPC_WIDTH-1:0] opc_raw;
    // Opcode as enum, may hold an unlisted value
    vdp_pkg::alu_op_e          opc;
    // Opcode is one of the listed operations
    logic                      opc_legal;
    // Operation needs both read ports
    logic                      opc_reads;

    //////////////////////////////////////////////////
    // Field extraction
    //////////////////////////////////////////////////

    // Second read address at the bottom
    assign raddr1  = inst[AW-1:0];
    assign raddr0  = inst[2*AW-1:AW];
    assign waddr   = inst[3*AW-1:2*AW];
    assign opc_raw = inst[OPC_LSB +: `VDP_OPC_WIDTH];
    assign opc     = vdp_pkg::alu_op_e'(opc_raw);

    //////////////////////////////////////////////////
    // Opcode classification
    //////////////////////////////////////////////////

    always_comb begin
        opc_legal = 1'b1;
        opc_reads = 1'b0;
        case (opc)
            vdp_pkg::OP_NOP,
            vdp_pkg::OP_STORE: opc_reads = 1'b0;
            vdp_pkg::OP_ADD,
            vdp_pkg::OP_SUB,
            vdp_pkg::OP_MUL,
            vdp_pkg::OP_PASS:  opc_reads = 1'b1;
            default:           opc_legal = 1'b0;
        endcase
    end

    // Strobes only for valid instructions
    assign wren = inst_vld && (opc == vdp_pkg::OP_STORE);
    assign rden = inst_vld && opc_reads;

    // Unlisted opcodes reach the ALU as NOP
    assign alu_op = opc_legal ? opc : vdp_pkg::OP_NOP;

    // One-cycle strobe per illegal instruction
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            illegal <= 1'b0;
        end else begin
            illegal <= inst_vld && !opc_legal;
        end
    end

endmodule

//--- src/lane_alu.sv
`include "vdp_settings.svh"

module lane_alu (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              rden,
    input  vdp_pkg::alu_op_e  alu_op,
    input  vdp_pkg::word_t    rdata0,
    input  vdp_pkg::word_t    rdata1,
    output vdp_pkg::word_t    result,
    output logic              result_vld
);

    // Lane geometry
    localparam int LW    = `VDP_LANE_WIDTH;
    localparam int LANES = `VDP_WORD_WIDTH / `VDP_LANE_WIDTH;

    // Operation delayed to meet the memory read data
    logic             op_vld_q;
    vdp_pkg::alu_op_e op_q;

    // Next result, all lanes
    vdp_pkg::word_t   result_d;

    // Single lane operation
    // Wrap-around arithmetic, product cut to lane width
    function automatic vdp_pkg::lane_t lane_calc(
        input vdp_pkg::alu_op_e op,
        input vdp_pkg::lane_t   a,
        input vdp_pkg::lane_t   b
    );
        vdp_pkg::lane_t res;
        case (op)
            vdp_pkg::OP_ADD:  res = a + b;
            vdp_pkg::OP_SUB:  res = a - b;
            vdp_pkg::OP_MUL:  res = a * b;
            vdp_pkg::OP_PASS: res = a;
            default:          res = '0;
        endcase
        return res;
    endfunction

    //////////////////////////////////////////////////
    // Stage 1, align with read data
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            op_vld_q <= 1'b0;
            op_q     <= vdp_pkg::OP_NOP;
        end else begin
            op_vld_q <= rden;
            op_q     <= alu_op;
        end
    end

    //////////////////////////////////////////////////
    // Lane compute
    //////////////////////////////////////////////////

    // Each lane on its own, no carry between lanes
    always_comb begin
        result_d = '0;
        for (int i = 0; i < LANES; i++) begin
            result_d[i*LW +: LW] = lane_calc(op_q, rdata0[i*LW +: LW], rdata1[i*LW +: LW]);
        end
    end

    //////////////////////////////////////////////////
    // Stage 2, result register
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result_vld <= 1'b0;
        end else begin
            result_vld <= op_vld_q;
        end
    end

    // Last result held while idle
    always_ff @(posedge clk) begin
        if (op_vld_q) begin
            result <= result_d;
        end
    end

endmodule

//--- src/vdp_pkg.sv
`include "vdp_settings.svh"

package vdp_pkg;

    // Instruction as it arrives on the top-level port
    typedef logic [`VDP_INST_WIDTH-1:0] inst_t;

    // Memory word and ALU result
    typedef logic [`VDP_WORD_WIDTH-1:0] word_t;

    // One 16-bit lane of a word
    typedef logic [`VDP_LANE_WIDTH-1:0] lane_t;

    // Memory address, same width for read and write fields
    typedef logic [`VDP_ADDR_WIDTH-1:0] addr_t;

    //////////////////////////////////////////////////
    // Opcodes
    //////////////////////////////////////////////////

    // Encoding of instruction bits 31:24
    // Values outside this list are illegal
    typedef enum logic [`VDP_OPC_WIDTH-1:0] {
        // No operation, no strobes
        OP_NOP   = 8'd0,
        // Write external data, data follows one cycle later
        OP_STORE = 8'd1,
        // Lane-wise arithmetic on two memory words
        OP_ADD   = 8'd2,
        OP_SUB   = 8'd3,
        // Low half of each lane product
        OP_MUL   = 8'd4,
        // Lanes of read port 0 unchanged
        OP_PASS  = 8'd5
    } alu_op_e;

endpackage

//--- src/vdp_settings.svh
`ifndef VDP_SETTINGS_SVH
`define VDP_SETTINGS_SVH

//////////////////////////////////////////////////
// Instruction format
//////////////////////////////////////////////////

// Full instruction word, upper 32 bits reserved
`define VDP_INST_WIDTH 64

// Opcode field, sits above the three address fields
`define VDP_OPC_WIDTH 8

// One address field, three of them packed at the bottom
`define VDP_ADDR_WIDTH 8

//////////////////////////////////////////////////
// Data path
//////////////////////////////////////////////////

// Memory word, also the result width
`define VDP_WORD_WIDTH 32

// Independent arithmetic lane, two per word
`define VDP_LANE_WIDTH 16

// Whole address range is backed by storage
`define VDP_MEM_DEPTH 256

`endif

//--- src/vec_datapath.sv
module vec_datapath (
    input  logic            clk,
    input  logic            arst_n,
    input  vdp_pkg::inst_t  inst,
    input  logic            inst_vld,
    input  vdp_pkg::word_t  wdata,
    output vdp_pkg::word_t  result,
    output logic            result_vld,
    output logic            illegal
);

    // Decoder strobes, level with the instruction
    logic             wren;
    logic             rden;

    // Decoded address fields
    vdp_pkg::addr_t   waddr;
    vdp_pkg::addr_t   raddr0;
    vdp_pkg::addr_t   raddr1;

    // Operation for the ALU
    vdp_pkg::alu_op_e alu_op;

    // Memory read data, one cycle after rden
    vdp_pkg::word_t   rdata0;
    vdp_pkg::word_t   rdata1;

    //////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////

    inst_decode inst_decode_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .inst     (inst),
        .inst_vld (inst_vld),
        .wren     (wren),
        .rden     (rden),
        .waddr    (waddr),
        .raddr0   (raddr0),
        .raddr1   (raddr1),
        .alu_op   (alu_op),
        .illegal  (illegal)
    );

    //////////////////////////////////////////////////
    // Memory and ALU
    //////////////////////////////////////////////////

    // Store data comes straight from the port, one cycle late
    data_mem data_mem_i (
        .clk    (clk),
        .arst_n (arst_n),
        .wren   (wren),
        .rden   (rden),
        .waddr  (waddr),
        .raddr0 (raddr0),
        .raddr1 (raddr1),
        .wdata  (wdata),
        .rdata0 (rdata0),
        .rdata1 (rdata1)
    );

    lane_alu lane_alu_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .rden       (rden),
        .alu_op     (alu_op),
        .rdata0     (rdata0),
        .rdata1     (rdata1),
        .result     (result),
        .result_vld (result_vld)
    );

endmodule

//--- vlog.f
+incdir+src
src/vdp_pkg.sv
src/inst_decode.sv
src/data_mem.sv
src/lane_alu.sv
src/vec_datapath.sv
bench/vec_datapath_assertions.sv
bench/tb_vec_datapath.sv
